//--- rtl/mipsPkg.sv
// shared widths, opcodes, ALU codes and instruction-word view; import where needed
package mipsPkg;

  // ====================
  // widths
  // ====================
  // one data word
  localparam int dataWidth = 32;
  // register index
  localparam int regAddrWidth = 5;
  // data-memory word address, 128 words
  localparam int memAddrWidth = 7;

  // ====================
  // opcodes
  // ====================
  localparam logic [5:0] opRType = 6'd0;
  localparam logic [5:0] opLw = 6'd35;
  localparam logic [5:0] opSw = 6'd43;
  localparam logic [5:0] opBeq = 6'd4;
  localparam logic [5:0] opJ = 6'd2;
  localparam logic [5:0] opJal = 6'd3;

  // r-type function field
  localparam logic [5:0] fnAdd = 6'd32;
  localparam logic [5:0] fnSub = 6'd34;
  localparam logic [5:0] fnAnd = 6'd36;
  localparam logic [5:0] fnOr = 6'd37;
  localparam logic [5:0] fnSlt = 6'd42;

  // ====================
  // alu control
  // ====================
  localparam logic [3:0] aluAnd = 4'd0;
  localparam logic [3:0] aluOr = 4'd1;
  localparam logic [3:0] aluAdd = 4'd2;
  localparam logic [3:0] aluSub = 4'd6;
  localparam logic [3:0] aluSlt = 4'd7;
  // result forced to zero
  localparam logic [3:0] aluNone = 4'd15;

  // jal destination
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

  // one instruction word, three decodings
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } rType;
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [15:0] imm;
    } iType;
    struct packed {
      logic [5:0] opcode;
      logic [25:0] target;
    } jType;
  } instrWord;

endpackage

//--- rtl/controlUnit.sv
// combinational main decoder and ALU control for the single-cycle core
module controlUnit (
  input  logic [5:0] opcode,
  input  logic [5:0] funct,
  output logic       regDst,
  output logic       aluSrc,
  output logic       memToReg,
  output logic       regWrite,
  output logic       memWrite,
  output logic       branch,
  output logic       jump,
  output logic       link,
  output logic [3:0] aluCtrl
);

  import mipsPkg::*;

  // ====================
  // main decoder
  // ====================
  always_comb begin
    // idle defaults, nothing written
    regDst = 1'b0;
    aluSrc = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    branch = 1'b0;
    jump = 1'b0;
    link = 1'b0;
    case (opcode)
      opRType: begin
        // rd destination, register operand
        regDst = 1'b1;
        regWrite = 1'b1;
      end
      opLw: begin
        aluSrc = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      opSw: begin
        // base + offset address, no register write
        aluSrc = 1'b1;
        memWrite = 1'b1;
      end
      opBeq: begin
        branch = 1'b1;
      end
      opJ: begin
        jump = 1'b1;
      end
      opJal: begin
        // link into r31
        jump = 1'b1;
        link = 1'b1;
        regWrite = 1'b1;
      end
      default: begin
        // unknown opcode acts as a no-op
      end
    endcase
  end

  // ====================
  // alu control
  // ====================
  always_comb begin
    case (opcode)
      // address calc
      opLw, opSw: aluCtrl = aluAdd;
      // compare by subtract
      opBeq: aluCtrl = aluSub;
      opRType: begin
        case (funct)
          fnAdd: aluCtrl = aluAdd;
          fnSub: aluCtrl = aluSub;
          fnAnd: aluCtrl = aluAnd;
          fnOr: aluCtrl = aluOr;
          fnSlt: aluCtrl = aluSlt;
          default: aluCtrl = aluNone;
        endcase
      end
      // jumps don't use the alu
      default: aluCtrl = aluNone;
    endcase
  end

endmodule

//--- rtl/registerFile.sv
// 32x32 general register file, two combinational reads, one clocked write
module registerFile (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             writeEn,
  input  logic [mipsPkg::regAddrWidth-1:0] readAddr1,
  input  logic [mipsPkg::regAddrWidth-1:0] readAddr2,
  input  logic [mipsPkg::regAddrWidth-1:0] writeAddr,
  input  logic [mipsPkg::dataWidth-1:0]    writeData,
  output logic [mipsPkg::dataWidth-1:0]    readData1,
  output logic [mipsPkg::dataWidth-1:0]    readData2
);

  import mipsPkg::*;

  // register storage
  logic [dataWidth-1:0] regs [2**regAddrWidth];

  // ====================
  // write port
  // ====================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // architectural state starts at zero
      for (int i = 0; i < 2**regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      // writes to r0 dropped
      regs[writeAddr] <= writeData;
    end
  end

  // ====================
  // read ports
  // ====================
  // r0 keeps its reset zero
  assign readData1 = regs[readAddr1];
  assign readData2 = regs[readAddr2];

endmodule

//--- rtl/alu.sv
// 32-bit ALU for add, sub, and, or and unsigned slt, with a zero flag for beq
module alu (
  input  logic [mipsPkg::dataWidth-1:0] operandA,
  input  logic [mipsPkg::dataWidth-1:0] operandB,
  input  logic [3:0]                    aluCtrl,
  output logic [mipsPkg::dataWidth-1:0] result,
  output logic                          zero
);

  import mipsPkg::*;

  // ====================
  // operations
  // ====================
  always_comb begin
    case (aluCtrl)
      aluAdd: result = operandA + operandB;
      aluSub: result = operandA - operandB;
      aluAnd: result = operandA & operandB;
      aluOr: result = operandA | operandB;
      // unsigned compare, kept as in the source core
      aluSlt: result = (operandA < operandB) ? dataWidth'(1) : '0;
      // aluNone and unknown codes
      default: result = '0;
    endcase
  end

  // equal operands under subtract
  // only meaningful for beq
  assign zero = (aluCtrl == aluSub) && (result == '0);

endmodule

//--- rtl/pcUnit.sv
// program counter with sequential, branch and jump next-pc selection
module pcUnit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          jump,
  input  logic                          branch,
  input  logic                          aluZero,
  input  logic [mipsPkg::dataWidth-1:0] branchOffset,
  input  logic [25:0]                   jumpTarget,
  output logic [mipsPkg::dataWidth-1:0] pc,
  output logic [mipsPkg::dataWidth-1:0] pcPlus8
);

  import mipsPkg::*;

  logic [dataWidth-1:0] pcPlus4;
  logic [dataWidth-1:0] branchAddr;
  logic [dataWidth-1:0] jumpAddr;
  logic [dataWidth-1:0] nextPc;

  // ====================
  // next address
  // ====================
  assign pcPlus4 = pc + dataWidth'(4);
  // link value for jal
  assign pcPlus8 = pc + dataWidth'(8);
  // word offset to byte offset
  assign branchAddr = pcPlus4 + {branchOffset[dataWidth-3:0], 2'b00};
  // region bits from pc+4
  assign jumpAddr = {pcPlus4[dataWidth-1:dataWidth-4], jumpTarget, 2'b00};

  // jump beats branch beats fall-through
  assign nextPc = jump ? jumpAddr :
                  (branch && aluZero) ? branchAddr : pcPlus4;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

//--- rtl/mipsCore.sv
// single-cycle core top; fetch and data memory live outside, one instruction per clock
module mipsCore (
  input  logic                             clk,
  input  logic                             rst,
  output logic [mipsPkg::dataWidth-1:0]    instrAddr,
  input  logic [mipsPkg::dataWidth-1:0]    instr,
  output logic [mipsPkg::dataWidth-1:0]    regWriteData,
  output logic                             cen,
  output logic                             wen,
  output logic [mipsPkg::memAddrWidth-1:0] memAddr,
  output logic [mipsPkg::dataWidth-1:0]    memWriteData,
  input  logic [mipsPkg::dataWidth-1:0]    memReadData
);

  import mipsPkg::*;

  // ====================
  // declarations
  // ====================
  instrWord iw;

  // decoder outputs
  logic regDst;
  logic aluSrc;
  logic memToReg;
  logic regWrite;
  logic memWrite;
  logic branch;
  logic jump;
  logic link;
  logic [3:0] aluCtrl;

  // datapath
  logic [dataWidth-1:0] signImm;
  logic [dataWidth-1:0] readData1;
  logic [dataWidth-1:0] readData2;
  logic [dataWidth-1:0] aluOperandB;
  logic [dataWidth-1:0] aluResult;
  logic aluZero;
  logic [regAddrWidth-1:0] writeAddr;
  logic [dataWidth-1:0] writeData;
  logic [dataWidth-1:0] pc;
  logic [dataWidth-1:0] pcPlus8;

  // fetched word, viewed per format
  assign iw = instr;

  // 16-bit immediate widened with its sign
  assign signImm = {{(dataWidth-16){iw.iType.imm[15]}}, iw.iType.imm};

  controlUnit u_control (
    .opcode  (iw.rType.opcode),
    .funct   (iw.rType.funct),
    .regDst  (regDst),
    .aluSrc  (aluSrc),
    .memToReg(memToReg),
    .regWrite(regWrite),
    .memWrite(memWrite),
    .branch  (branch),
    .jump    (jump),
    .link    (link),
    .aluCtrl (aluCtrl)
  );

  // ====================
  // operand and result selects
  // ====================
  // jal overrides rd/rt with r31
  assign writeAddr = link ? linkReg : (regDst ? iw.rType.rd : iw.rType.rt);
  // immediate for lw/sw
  assign aluOperandB = aluSrc ? signImm : readData2;
  // write-back: return address, load data, or alu
  assign writeData = link ? pcPlus8 : (memToReg ? memReadData : aluResult);

  registerFile u_regFile (
    .clk      (clk),
    .rst      (rst),
    .writeEn  (regWrite),
    .readAddr1(iw.rType.rs),
    .readAddr2(iw.rType.rt),
    .writeAddr(writeAddr),
    .writeData(writeData),
    .readData1(readData1),
    .readData2(readData2)
  );

  alu u_alu (
    .operandA(readData1),
    .operandB(aluOperandB),
    .aluCtrl (aluCtrl),
    .result  (aluResult),
    .zero    (aluZero)
  );

  pcUnit u_pc (
    .clk         (clk),
    .rst         (rst),
    .jump        (jump),
    .branch      (branch),
    .aluZero     (aluZero),
    .branchOffset(signImm),
    .jumpTarget  (iw.jType.target),
    .pc          (pc),
    .pcPlus8     (pcPlus8)
  );

  // ====================
  // outside ports
  // ====================
  assign instrAddr = pc;
  // chip enable low for lw and sw only
  assign cen = ~(memToReg | memWrite);
  assign wen = ~memWrite;
  // byte address to word address
  assign memAddr = aluResult[memAddrWidth+1:2];
  assign memWriteData = readData2;
  // observed every cycle
  assign regWriteData = writeData;

endmodule

//--- test/clockGen.sv
// testbench clock source, 4 ns period; instantiate once in the testbench top
module clockGen (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  // half of the 4 ns period
  localparam int halfPeriod = 2;

  initial begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

endmodule

//--- test/mipsCoreProperties.sv
// concurrent checks on the core's memory strobes and fetch address, bound into mipsCore
module mipsCoreProperties (
  input logic                          clk,
  input logic                          rst,
  input logic                          cen,
  input logic                          wen,
  input logic [mipsPkg::dataWidth-1:0] instrAddr
);

  timeunit 1ns;
  timeprecision 100ps;

  // ====================
  // strobes
  // ====================
  // a write never happens without chip enable
  writeNeedsEnable: assert property (@(posedge clk) disable iff (!rst) !wen |-> !cen)
    else $error("wen low while cen is high");

  // memory idle while the core is held in reset
  idleInReset: assert property (@(posedge clk) !rst |-> (cen && wen))
    else $error("memory strobe active during reset");

  // fetch address always on a word boundary
  fetchAligned: assert property (@(posedge clk) disable iff (!rst) instrAddr[1:0] == 2'b00)
    else $error("instrAddr not word aligned");

endmodule

bind mipsCore mipsCoreProperties u_props (
  .clk      (clk),
  .rst      (rst),
  .cen      (cen),
  .wen      (wen),
  .instrAddr(instrAddr)
);

//--- test/mipsCoreTb.sv
// testbench top: memory models, random program, reference ISA model; run as the sim top
module mipsCoreTb;

  timeunit 1ns;
  timeprecision 100ps;

  import mipsPkg::*;

  // ====================
  // test setup
  // ====================
  localparam int clkPeriod = 4;
  localparam int resetCycles = 5;
  // instruction mixes
  localparam int memMix = 0;
  localparam int arithMix = 1;
  localparam int flowMix = 2;
  localparam int zeroMix = 3;
  // five tests, each with its own reset, plus slack
  localparam int totalCycles = 5 * resetCycles + 2 + 200 + 300 + 300 + 200;
  localparam int watchdogLimit = (totalCycles + 100) * clkPeriod;

  logic clk;
  logic rst;
  logic [31:0] instr;
  logic [31:0] instrAddr;
  logic [31:0] regWriteData;
  logic cen;
  logic wen;
  logic [memAddrWidth-1:0] memAddr;
  logic [31:0] memWriteData;
  logic [31:0] memReadData;

  // memories seen by the core
  logic [31:0] imem [logic [29:0]];
  logic [31:0] dmem [2**memAddrWidth];
  // reference state
  logic [31:0] refRegs [32];
  logic [31:0] refMem [2**memAddrWidth];
  logic [31:0] refPc;

  integer seed;
  int errCount;
  int checkCount;

  clockGen u_clk (
    .clk(clk)
  );

  mipsCore u_dut (
    .clk         (clk),
    .rst         (rst),
    .instrAddr   (instrAddr),
    .instr       (instr),
    .regWriteData(regWriteData),
    .cen         (cen),
    .wen         (wen),
    .memAddr     (memAddr),
    .memWriteData(memWriteData),
    .memReadData (memReadData)
  );

  // read port of the data SRAM
  assign memReadData = dmem[memAddr];

  // ====================
  // helpers
  // ====================
  task automatic checkVal(input string what, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    assert (got === exp) else begin
      errCount++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int randBelow(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // small index range makes r0 a frequent target
  function automatic logic [4:0] pickReg(input int mode);
    if (mode == zeroMix) begin
      return 5'(randBelow(4));
    end
    return 5'(randBelow(32));
  endfunction

  // random legal instruction for a word address
  function automatic logic [31:0] genInstr(input int mode, input logic [29:0] pcWord);
    instrWord w;
    int kind;
    int target;
    int offset;
    w = '0;
    // kind 0 lw, 1 sw, 2 r-type, 3 beq, 4 j, 5 jal
    case (mode)
      memMix: kind = randBelow(2);
      arithMix: kind = (randBelow(4) == 0) ? 0 : 2;
      default: kind = randBelow(8);
    endcase
    if (kind > 5) begin
      kind = 2;
    end
    // control targets kept inside the first 64 words
    target = randBelow(64);
    case (kind)
      0, 1: begin
        w.iType.opcode = (kind == 0) ? opLw : opSw;
        // base r0, the immediate picks the word
        w.iType.rt = pickReg(mode);
        w.iType.imm = 16'(randBelow(128) * 4);
      end
      2: begin
        w.rType.rs = pickReg(mode);
        w.rType.rt = pickReg(mode);
        w.rType.rd = pickReg(mode);
        case (randBelow(6))
          0: w.rType.funct = fnAdd;
          1: w.rType.funct = fnSub;
          2: w.rType.funct = fnAnd;
          3: w.rType.funct = fnOr;
          4: w.rType.funct = fnSlt;
          // nor, not implemented
          default: w.rType.funct = 6'h27;
        endcase
      end
      3: begin
        w.iType.opcode = opBeq;
        w.iType.rs = pickReg(mode);
        w.iType.rt = pickReg(mode);
        offset = target - int'(pcWord) - 1;
        w.iType.imm = 16'(offset);
      end
      default: begin
        w.jType.opcode = (kind == 4) ? opJ : opJal;
        w.jType.target = 26'(target);
      end
    endcase
    return w;
  endfunction

  // ====================
  // reference model
  // ====================
  // one instruction by the ISA rules, checking the core's outputs on the way
  task automatic stepModel(input logic [31:0] word);
    instrWord w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] addr;
    logic [31:0] pc4;
    logic [31:0] nextPc;
    logic [31:0] expVal;
    logic [4:0] dst;
    logic wr;
    logic isMem;
    w = word;
    a = refRegs[w.iType.rs];
    b = refRegs[w.iType.rt];
    simm = {{16{w.iType.imm[15]}}, w.iType.imm};
    addr = a + simm;
    pc4 = refPc + 32'd4;
    nextPc = pc4;
    expVal = '0;
    dst = w.rType.rd;
    wr = 1'b0;
    case (w.rType.opcode)
      opRType: begin
        wr = 1'b1;
        case (w.rType.funct)
          fnAdd: expVal = a + b;
          fnSub: expVal = a - b;
          fnAnd: expVal = a & b;
          fnOr: expVal = a | b;
          // unsigned compare
          fnSlt: expVal = {31'd0, a < b};
          default: expVal = '0;
        endcase
      end
      opLw: begin
        wr = 1'b1;
        dst = w.iType.rt;
        expVal = refMem[addr[8:2]];
        checkVal("load address", 32'(memAddr), 32'(addr[8:2]));
      end
      opSw: begin
        checkVal("store address", 32'(memAddr), 32'(addr[8:2]));
        checkVal("store data", memWriteData, b);
        refMem[addr[8:2]] = b;
      end
      opBeq: begin
        if (a == b) begin
          nextPc = pc4 + {simm[29:0], 2'b00};
        end
      end
      opJ: nextPc = {pc4[31:28], w.jType.target, 2'b00};
      opJal: begin
        wr = 1'b1;
        dst = linkReg;
        // return address past the missing delay slot
        expVal = refPc + 32'd8;
        nextPc = {pc4[31:28], w.jType.target, 2'b00};
      end
      default: begin
      end
    endcase
    isMem = (w.rType.opcode == opLw) || (w.rType.opcode == opSw);
    checkVal("cen", 32'(cen), isMem ? 32'd0 : 32'd1);
    checkVal("wen", 32'(wen), (w.rType.opcode == opSw) ? 32'd0 : 32'd1);
    if (wr) begin
      checkVal("write-back data", regWriteData, expVal);
      // r0 stays zero in the model too
      if (dst != '0) begin
        refRegs[dst] = expVal;
      end
    end
    refPc = nextPc;
  endtask

  // ====================
  // stimulus
  // ====================
  task automatic applyReset();
    rst = 1'b0;
    instr = '0;
    imem.delete();
    // nop at the reset vector
    imem[30'd0] = '0;
    refPc = '0;
    foreach (refRegs[i]) begin
      refRegs[i] = '0;
    end
    repeat (resetCycles) begin
      @(posedge clk);
      #1;
      checkVal("reset fetch address", instrAddr, '0);
      checkVal("reset cen", 32'(cen), 32'd1);
      checkVal("reset wen", 32'(wen), 32'd1);
    end
    rst = 1'b1;
  endtask

  // starts and ends 1 ns past a rising edge
  task automatic runCycles(input int mode, input int cycles);
    logic [29:0] word;
    logic doWrite;
    logic [memAddrWidth-1:0] wrAddr;
    logic [31:0] wrData;
    repeat (cycles) begin
      checkVal("fetch address", instrAddr, refPc);
      word = instrAddr[31:2];
      // lazy fill on first fetch
      if (!imem.exists(word)) begin
        imem[word] = genInstr(mode, word);
      end
      instr = imem[word];
      #1;
      stepModel(instr);
      // SRAM write lands on the edge
      doWrite = !cen && !wen;
      wrAddr = memAddr;
      wrData = memWriteData;
      @(posedge clk);
      if (doWrite) begin
        dmem[wrAddr] = wrData;
      end
      #1;
    end
  endtask

  task automatic runTest(input string name, input int mode, input int cycles);
    int errBefore;
    errBefore = errCount;
    applyReset();
    runCycles(mode, cycles);
    $display("test %s finished: %0d cycles, %0d errors", name, cycles, errCount - errBefore);
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    seed = 32'hf4a3;
    rst = 1'b0;
    instr = '0;
    errCount = 0;
    checkCount = 0;
    for (int i = 0; i < 2**memAddrWidth; i++) begin
      dmem[i] = $random(seed);
      refMem[i] = dmem[i];
    end
    runTest("reset", arithMix, 2);
    runTest("memory mix", memMix, 200);
    runTest("arithmetic mix", arithMix, 300);
    runTest("control flow", flowMix, 300);
    runTest("register zero", zeroMix, 200);
    $display("summary: %0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // hang guard
  initial begin
    #(watchdogLimit);
    $display("watchdog expired at %0t ns, the tests did not finish in time", $time);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- verilog.f
rtl/mipsPkg.sv
rtl/controlUnit.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/pcUnit.sv
rtl/mipsCore.sv
test/clockGen.sv
test/mipsCoreProperties.sv
test/mipsCoreTb.sv

//--- Makefile
# Verilator build and run for the single-cycle core testbench

VERILATOR ?= verilator
TOP       ?= mipsCoreTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# output goes to the terminal; status comes from the pass line
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
